/* vanilla_core.f */
hdl/core_pkg.sv
hdl/fetch_stage.sv
hdl/reg_file.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/writeback_stage.sv
hdl/vanilla_core.sv
testbench/core_checker.sv
testbench/core_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module core_tb -f vanilla_core.f -o core_tb_sim

output="$(./obj_dir/core_tb_sim)"
echo "$output"

if echo "$output" | grep -q "^Finished with no errors$"; then
    exit 0
else
    exit 1
fi

/* testbench/core_tb.sv */
module core_tb;

    timeunit 1ns;
    timeprecision 1ps;

    // Instruction kinds of the generated programs with R-type first
    typedef enum logic [4:0] {
        K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT,
        K_ADDI, K_ANDI, K_ORI, K_XORI, K_LUI,
        K_LW, K_SW, K_BEQ, K_BNE, K_JAL
    } kind_e;

    typedef struct packed {
        kind_e       kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;
    } instr_s;

    logic                  clk = 1'b0;
    logic                  reset = 1'b1;
    core_pkg::net_packet_s net_packet_i = '0;
    core_pkg::mem_req_s    mem_req_o;
    core_pkg::mem_resp_s   mem_resp_i = '0;

    instr_s       prog [256];
    int           prog_len;
    logic [63:0]  exp_q [$];
    logic [31:0]  resp_mem [64];
    string        cur_name = "none";
    int           obs_cnt = 0;
    int           store_errors = 0;
    int           delay;
    bit           busy;
    bit           timed_out = 0;
    int           tests_run = 0;
    int           tests_failed = 0;

    vanilla_core dut_i (
        .clk          (clk),
        .reset        (reset),
        .net_packet_i (net_packet_i),
        .mem_req_o    (mem_req_o),
        .mem_resp_i   (mem_resp_i)
    );

    initial
    begin
        forever #4 clk = ~clk;
    end

    // Initial data words from 0x400 to 0x4FC depend on the full address
    function automatic logic [31:0] fill_word(int idx);
        logic [31:0] addr;
        addr = 32'h400 + 32'(4 * idx);
        return (addr * 32'h9e3779b1) ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a0f0f;
    endfunction

    function automatic logic [31:0] rand_imm12();
        logic [11:0] v;
        v = 12'($urandom);
        return {{20{v[11]}}, v};
    endfunction

    // RV32I encodings taken from the ISA formats
    function automatic logic [31:0] encode(instr_s r);
        case (r.kind)
            K_ADD:  return {7'b0000000, r.rs2, r.rs1, 3'b000, r.rd, 7'b0110011};
            K_SUB:  return {7'b0100000, r.rs2, r.rs1, 3'b000, r.rd, 7'b0110011};
            K_AND:  return {7'b0000000, r.rs2, r.rs1, 3'b111, r.rd, 7'b0110011};
            K_OR:   return {7'b0000000, r.rs2, r.rs1, 3'b110, r.rd, 7'b0110011};
            K_XOR:  return {7'b0000000, r.rs2, r.rs1, 3'b100, r.rd, 7'b0110011};
            K_SLT:  return {7'b0000000, r.rs2, r.rs1, 3'b010, r.rd, 7'b0110011};
            K_ADDI: return {r.imm[11:0], r.rs1, 3'b000, r.rd, 7'b0010011};
            K_ANDI: return {r.imm[11:0], r.rs1, 3'b111, r.rd, 7'b0010011};
            K_ORI:  return {r.imm[11:0], r.rs1, 3'b110, r.rd, 7'b0010011};
            K_XORI: return {r.imm[11:0], r.rs1, 3'b100, r.rd, 7'b0010011};
            K_LUI:  return {r.imm[31:12], r.rd, 7'b0110111};
            K_LW:   return {r.imm[11:0], r.rs1, 3'b010, r.rd, 7'b0000011};
            K_SW:   return {r.imm[11:5], r.rs2, r.rs1, 3'b010, r.imm[4:0], 7'b0100011};
            K_BEQ:  return {r.imm[12], r.imm[10:5], r.rs2, r.rs1, 3'b000, r.imm[4:1],
                            r.imm[11], 7'b1100011};
            K_BNE:  return {r.imm[12], r.imm[10:5], r.rs2, r.rs1, 3'b001, r.imm[4:1],
                            r.imm[11], 7'b1100011};
            K_JAL:  return {r.imm[20], r.imm[10:1], r.imm[11], r.imm[19:12], r.rd,
                            7'b1101111};
            default: return 32'h0;
        endcase
    endfunction

    function automatic logic [31:0] alu_model(kind_e k, logic [31:0] a, logic [31:0] b);
        case (k)
            K_ADD, K_ADDI: return a + b;
            K_SUB:         return a - b;
            K_AND, K_ANDI: return a & b;
            K_OR, K_ORI:   return a | b;
            K_XOR, K_XORI: return a ^ b;
            K_SLT:         return {31'b0, $signed(a) < $signed(b)};
            default:       return b;
        endcase
    endfunction

    // Mode 0 ALU only, 1 small register set with memory, 2 branch heavy, else all
    function automatic instr_s random_instr(int mode, int i, int body_end);
        instr_s r;
        int     sel;
        int     k;
        int     nregs;
        nregs = (mode == 1) ? 4 : 8;
        r.rd  = 5'($urandom % nregs);
        r.rs1 = 5'($urandom % nregs);
        r.rs2 = 5'($urandom % nregs);
        r.imm = rand_imm12();
        if (mode == 0)
            sel = int'($urandom % 11);
        else if (mode == 1)
            sel = int'($urandom % 13);
        else
            sel = int'($urandom % 16);
        if (mode == 2 && ($urandom % 2) == 1)
            sel = 13 + int'($urandom % 3);
        r.kind = kind_e'(5'(sel));
        case (r.kind)
            K_LUI: r.imm = {20'($urandom), 12'b0};
            K_LW:
            begin
                r.rs1 = 5'd0;
                r.imm = 32'h400 + 32'(4 * ($urandom % 32));
            end
            K_SW:
            begin
                r.rs1 = 5'd0;
                r.imm = 32'h400 + 32'(4 * ($urandom % 16));
            end
            K_BEQ, K_BNE, K_JAL:
            begin
                // Forward only and never past the first epilogue store
                k = 1 + int'($urandom % 3);
                if (i + k > body_end)
                    k = body_end - i;
                r.imm = 32'(4 * k);
                if (r.kind != K_JAL && ($urandom % 2) == 1)
                    r.rs2 = r.rs1;
            end
            default: ;
        endcase
        return r;
    endfunction

    // Prologue sets x1..x7, epilogue stores x0..x7, then a JAL to itself
    task automatic gen_program(int mode, int n);
        for (int r = 1; r < 8; r++)
            prog[r-1] = '{kind: K_ADDI, rd: 5'(r), rs1: 5'd0, rs2: 5'd0, imm: rand_imm12()};
        for (int i = 7; i < 7 + n; i++)
            prog[i] = random_instr(mode, i, 7 + n);
        for (int r = 0; r < 8; r++)
            prog[7+n+r] = '{kind: K_SW, rd: 5'd0, rs1: 5'd0, rs2: 5'(r),
                            imm: 32'h400 + 32'(4 * (56 + r))};
        prog[15+n] = '{kind: K_JAL, rd: 5'd0, rs1: 5'd0, rs2: 5'd0, imm: 32'h0};
        prog_len = n + 16;
    endtask

    // ISA model that fills the expected store sequence
    task automatic run_model(logic [31:0] base);
        logic [31:0] regs [32];
        logic [31:0] mem [64];
        logic [31:0] b;
        instr_s      r;
        int          i;
        int          steps;
        for (int j = 0; j < 32; j++)
            regs[j] = 32'h0;
        for (int j = 0; j < 64; j++)
            mem[j] = fill_word(j);
        i = 0;
        steps = 0;
        while (i != prog_len - 1 && steps < 4096)
        begin
            r = prog[i];
            b = (r.kind <= K_SLT) ? regs[r.rs2] : r.imm;
            case (r.kind)
                K_SW:
                begin
                    mem[r.imm[7:2]] = regs[r.rs2];
                    exp_q.push_back({r.imm, regs[r.rs2]});
                    i++;
                end
                K_LW:
                begin
                    regs[r.rd] = mem[r.imm[7:2]];
                    i++;
                end
                K_BEQ, K_BNE:
                begin
                    if ((regs[r.rs1] == regs[r.rs2]) != (r.kind == K_BNE))
                        i += int'(r.imm >> 2);
                    else
                        i++;
                end
                K_JAL:
                begin
                    regs[r.rd] = base + 32'(4 * i + 4);
                    i += int'(r.imm >> 2);
                end
                default:
                begin
                    regs[r.rd] = alu_model(r.kind, regs[r.rs1], b);
                    i++;
                end
            endcase
            regs[0] = 32'h0;
            steps++;
        end
    endtask

    // Memory responder acks after 0 to 3 idle cycles and checks stores on completion
    always @(posedge clk)
    begin
        if (reset)
        begin
            mem_resp_i <= '0;
            obs_cnt    <= 0;
            busy = 0;
            for (int j = 0; j < 64; j++)
                resp_mem[j] = fill_word(j);
        end
        else if (mem_resp_i.ack)
        begin
            mem_resp_i.ack <= 1'b0;
            busy = 0;
            if (mem_req_o.valid && mem_req_o.wen)
            begin
                resp_mem[mem_req_o.addr[7:2]] = mem_req_o.wdata;
                if (obs_cnt >= exp_q.size())
                begin
                    $display("test %s: unexpected extra store to %h with data %h",
                             cur_name, mem_req_o.addr, mem_req_o.wdata);
                    store_errors <= store_errors + 1;
                end
                else if (exp_q[obs_cnt] != {mem_req_o.addr, mem_req_o.wdata})
                begin
                    $display("CHECK FAILED test=%s store %0d expected %h:%h actual %h:%h",
                             cur_name, obs_cnt, exp_q[obs_cnt][63:32], exp_q[obs_cnt][31:0],
                             mem_req_o.addr, mem_req_o.wdata);
                    store_errors <= store_errors + 1;
                end
                obs_cnt <= obs_cnt + 1;
            end
        end
        else if (mem_req_o.valid)
        begin
            if (!busy)
            begin
                busy = 1;
                delay = int'($urandom % 4);
            end
            if (delay == 0)
                mem_resp_i <= '{ack: 1'b1, rdata: resp_mem[mem_req_o.addr[7:2]]};
            else
                delay--;
        end
    end

    task automatic run_test(string name, int mode, int n, logic [31:0] base, bit restart);
        int cyc;
        int settle;
        int err_before;
        int assert_before;
        cur_name = name;
        gen_program(mode, n);
        exp_q.delete();
        run_model(base);
        @(posedge clk);
        reset <= 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        err_before = store_errors;
        assert_before = dut_i.checker_i.assert_fails;
        // Load the program word by word while IDLE and then start it
        for (int i = 0; i < prog_len; i++)
        begin
            @(posedge clk);
            net_packet_i <= '{valid: 1'b1, op: core_pkg::INSTR,
                              addr: base + 32'(4 * i), data: encode(prog[i])};
        end
        @(posedge clk);
        net_packet_i <= '{valid: 1'b1, op: core_pkg::PC, addr: base, data: 32'h0};
        @(posedge clk);
        net_packet_i <= '0;
        cyc = 0;
        settle = 0;
        // Keep running after the last store so repeated stores show up
        while (settle < 32 && !timed_out)
        begin
            @(posedge clk);
            cyc++;
            // PC packet during RUN must be ignored
            if (restart && cyc == 20)
                net_packet_i <= '{valid: 1'b1, op: core_pkg::PC, addr: 32'h0, data: 32'h0};
            if (restart && cyc == 21)
                net_packet_i <= '0;
            if (obs_cnt >= exp_q.size())
                settle++;
            if (cyc > 64 * prog_len)
            begin
                $display("test %s: timeout, %0d of %0d stores seen after %0d cycles",
                         name, obs_cnt, exp_q.size(), cyc);
                timed_out = 1;
            end
        end
        tests_run++;
        if (timed_out || store_errors != err_before
            || dut_i.checker_i.assert_fails != assert_before)
        begin
            tests_failed++;
            $display("test %-12s FAILED  stores %0d", name, exp_q.size());
        end
        else
            $display("test %-12s ok      stores %0d", name, exp_q.size());
    endtask

    initial
    begin
        void'($urandom(32'hb330fabc));
        run_test("alu", 0, 40, 32'h0, 1'b0);
        if (!timed_out)
            run_test("forward", 1, 60, 32'h0, 1'b0);
        if (!timed_out)
            run_test("control", 2, 60, 32'h0, 1'b0);
        if (!timed_out)
            run_test("backpressure", 3, 80, 32'h0, 1'b0);
        // Second program at a nonzero base
        if (!timed_out)
            run_test("restart", 4, 60, 32'h200, 1'b1);
        $display("tests run %0d, failed %0d, store errors %0d, assertion failures %0d",
                 tests_run, tests_failed, store_errors, dut_i.checker_i.assert_fails);
        if (store_errors == 0 && !timed_out && tests_failed == 0
            && dut_i.checker_i.assert_fails == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

/* testbench/core_checker.sv */
module core_checker (
    input logic                clk,
    input logic                reset,
    input core_pkg::mem_req_s  mem_req_i,
    input core_pkg::mem_resp_s mem_resp_i,
    input logic                redirect_valid_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // Count of failed assertions
    int assert_fails = 0;

    // Request held stable until its ack edge
    assert property (@(posedge clk) disable iff (reset)
        (mem_req_i.valid && !mem_resp_i.ack) |=> (mem_req_i.valid && $stable(mem_req_i)))
    else
    begin
        $error("memory request changed before ack");
        assert_fails++;
    end

    // Reset clears the execute stage so no request follows it
    assert property (@(posedge clk) reset |=> !mem_req_i.valid)
    else
    begin
        $error("memory request valid right after reset");
        assert_fails++;
    end

    // Redirect flushes decode/execute so the next cycle is a bubble
    assert property (@(posedge clk) disable iff (reset)
        redirect_valid_i |=> !mem_req_i.valid)
    else
    begin
        $error("memory request issued in the cycle after a redirect");
        assert_fails++;
    end

endmodule

bind vanilla_core core_checker checker_i (
    .clk              (clk),
    .reset            (reset),
    .mem_req_i        (mem_req_o),
    .mem_resp_i       (mem_resp_i),
    .redirect_valid_i (redirect_valid)
);

/* hdl/vanilla_core.sv */
module vanilla_core (
    input  logic                   clk,
    input  logic                   reset,
    input  core_pkg::net_packet_s  net_packet_i,
    output core_pkg::mem_req_s     mem_req_o,
    input  core_pkg::mem_resp_s    mem_resp_i
);

    core_pkg::fetch_id_s                   fetch_id;
    core_pkg::id_exe_s                     id_exe;
    core_pkg::wb_s                         wb;
    core_pkg::state_e                      state;
    logic                                  imem_write;
    logic                                  stall;
    logic                                  redirect_valid;
    logic [core_pkg::XLEN-1:0]             redirect_pc;
    logic [core_pkg::XLEN-1:0]             result;
    logic [core_pkg::REG_ADDR_WIDTH-1:0]   rd;
    logic                                  writes_rf;

    // PC, packet handling and instruction memory
    fetch_stage fetch_stage_i (
        .clk              (clk),
        .reset            (reset),
        .net_packet_i     (net_packet_i),
        .stall_i          (stall),
        .redirect_valid_i (redirect_valid),
        .redirect_pc_i    (redirect_pc),
        .fetch_id_o       (fetch_id),
        .state_o          (state),
        .imem_write_o     (imem_write)
    );

    // Decoder and register file, flushed by redirect
    decode_stage decode_stage_i (
        .clk        (clk),
        .reset      (reset),
        .fetch_id_i (fetch_id),
        .stall_i    (stall),
        .flush_i    (redirect_valid),
        .wb_i       (wb),
        .id_exe_o   (id_exe)
    );

    // ALU, branches and the data-memory port
    execute_stage execute_stage_i (
        .clk              (clk),
        .reset            (reset),
        .id_exe_i         (id_exe),
        .wb_i             (wb),
        .mem_resp_i       (mem_resp_i),
        .state_i          (state),
        .imem_write_i     (imem_write),
        .mem_req_o        (mem_req_o),
        .result_o         (result),
        .rd_o             (rd),
        .writes_rf_o      (writes_rf),
        .stall_o          (stall),
        .redirect_valid_o (redirect_valid),
        .redirect_pc_o    (redirect_pc)
    );

    writeback_stage writeback_stage_i (
        .clk         (clk),
        .reset       (reset),
        .stall_i     (stall),
        .result_i    (result),
        .rd_i        (rd),
        .writes_rf_i (writes_rf),
        .wb_o        (wb)
    );

endmodule

/* hdl/writeback_stage.sv */
module writeback_stage (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   stall_i,
    input  logic [core_pkg::XLEN-1:0]              result_i,
    input  logic [core_pkg::REG_ADDR_WIDTH-1:0]    rd_i,
    input  logic                                   writes_rf_i,
    output core_pkg::wb_s                          wb_o
);

    core_pkg::wb_s wb_r;

    // Holds under stall so execute keeps its forwarded operand
    // A held write repeats the same value, which is harmless
    always_ff @(posedge clk)
    begin
        if (reset)
            wb_r <= '0;
        else if (!stall_i)
            wb_r <= '{op_writes_rf: writes_rf_i, rd: rd_i, data: result_i};
    end

    assign wb_o = wb_r;

endmodule

/* hdl/execute_stage.sv */
module execute_stage (
    input  logic                                   clk,
    input  logic                                   reset,
    input  core_pkg::id_exe_s                      id_exe_i,
    input  core_pkg::wb_s                          wb_i,
    input  core_pkg::mem_resp_s                    mem_resp_i,
    input  core_pkg::state_e                       state_i,
    input  logic                                   imem_write_i,
    output core_pkg::mem_req_s                     mem_req_o,
    output logic [core_pkg::XLEN-1:0]              result_o,
    output logic [core_pkg::REG_ADDR_WIDTH-1:0]    rd_o,
    output logic                                   writes_rf_o,
    output logic                                   stall_o,
    output logic                                   redirect_valid_o,
    output logic [core_pkg::XLEN-1:0]              redirect_pc_o
);

    core_pkg::decode_s          dec;
    logic [core_pkg::XLEN-1:0]  rs1_val;
    logic [core_pkg::XLEN-1:0]  rs2_val;
    logic [core_pkg::XLEN-1:0]  op_b;
    logic [core_pkg::XLEN-1:0]  alu_result;
    logic [core_pkg::XLEN-1:0]  load_data;
    logic [core_pkg::XLEN-1:0]  load_data_r;
    logic                       mem_op;
    logic                       mem_done_r;
    logic                       mem_wait;
    logic                       taken;
    logic                       stall;

    assign dec = id_exe_i.decode;

    // Forward from writeback, x0 never forwards
    assign rs1_val = (wb_i.op_writes_rf && (wb_i.rd == id_exe_i.rs1) && (id_exe_i.rs1 != '0))
                     ? wb_i.data : id_exe_i.rs1_val;
    assign rs2_val = (wb_i.op_writes_rf && (wb_i.rd == id_exe_i.rs2) && (id_exe_i.rs2 != '0))
                     ? wb_i.data : id_exe_i.rs2_val;
    assign op_b    = dec.use_imm ? id_exe_i.imm : rs2_val;

    // Loads and stores use ADD for the address
    always_comb
    begin
        case (dec.alu_op)
            core_pkg::ADD:    alu_result = rs1_val + op_b;
            core_pkg::SUB:    alu_result = rs1_val - op_b;
            core_pkg::AND:    alu_result = rs1_val & op_b;
            core_pkg::OR:     alu_result = rs1_val | op_b;
            core_pkg::XOR:    alu_result = rs1_val ^ op_b;
            core_pkg::SLT:    alu_result = core_pkg::XLEN'($signed(rs1_val) < $signed(op_b));
            default:          alu_result = op_b;
        endcase
    end

    // Static not-taken, so any taken branch or jump redirects
    assign taken = dec.is_jump || (dec.is_branch && ((rs1_val == rs2_val) != dec.branch_ne));

    // Memory op done flag covers an ack that lands during another stall
    assign mem_op   = id_exe_i.valid && (dec.is_load || dec.is_store);
    assign mem_wait = mem_op && !mem_done_r && !mem_resp_i.ack;
    assign stall    = mem_wait || imem_write_i || (state_i != core_pkg::RUN);

    assign mem_req_o = '{valid: mem_op && !mem_done_r,
                         wen:   dec.is_store,
                         addr:  alu_result,
                         wdata: rs2_val};

    always_ff @(posedge clk)
    begin
        if (reset || !stall)
            mem_done_r <= 1'b0;
        else if (mem_req_o.valid && mem_resp_i.ack)
            mem_done_r <= 1'b1;
    end

    // Hold read data while the stage waits on a non-memory stall
    always_ff @(posedge clk)
    begin
        if (mem_req_o.valid && mem_resp_i.ack)
            load_data_r <= mem_resp_i.rdata;
    end

    assign load_data = mem_done_r ? load_data_r : mem_resp_i.rdata;

    always_comb
    begin
        if (dec.is_load)
            result_o = load_data;
        else if (dec.is_jump)
            result_o = id_exe_i.pc + core_pkg::XLEN'(core_pkg::PC_STEP);
        else
            result_o = alu_result;
    end

    assign rd_o             = id_exe_i.rd;
    // Bubbles never write
    assign writes_rf_o      = id_exe_i.valid && dec.op_writes_rf;
    assign stall_o          = stall;
    assign redirect_valid_o = id_exe_i.valid && taken && !stall;
    assign redirect_pc_o    = id_exe_i.pc + id_exe_i.imm;

endmodule

/* hdl/decode_stage.sv */
module decode_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  core_pkg::fetch_id_s   fetch_id_i,
    input  logic                  stall_i,
    input  logic                  flush_i,
    input  core_pkg::wb_s         wb_i,
    output core_pkg::id_exe_s     id_exe_o
);

    logic [core_pkg::XLEN-1:0]             instr;
    core_pkg::opcode_e                     opcode;
    core_pkg::decode_s                     dec;
    logic [core_pkg::XLEN-1:0]             imm;
    logic [core_pkg::REG_ADDR_WIDTH-1:0]   rs1;
    logic [core_pkg::REG_ADDR_WIDTH-1:0]   rs2;
    logic [core_pkg::XLEN-1:0]             rf_rs1_val;
    logic [core_pkg::XLEN-1:0]             rf_rs2_val;
    logic [core_pkg::XLEN-1:0]             rs1_val;
    logic [core_pkg::XLEN-1:0]             rs2_val;
    core_pkg::id_exe_s                     id_exe_r;

    // funct3 to ALU op, shared by OP and OP_IMM
    function automatic core_pkg::alu_op_e alu_sel(input logic [2:0] funct3, input logic sub);
        core_pkg::alu_op_e op;
        case (funct3)
            3'b000:  op = sub ? core_pkg::SUB : core_pkg::ADD;
            3'b010:  op = core_pkg::SLT;
            3'b100:  op = core_pkg::XOR;
            3'b110:  op = core_pkg::OR;
            3'b111:  op = core_pkg::AND;
            default: op = core_pkg::ADD;
        endcase
        return op;
    endfunction

    assign instr  = fetch_id_i.instruction;
    assign opcode = core_pkg::opcode_e'(instr[6:0]);

    // Control flags and sign-extended immediate per format
    always_comb
    begin
        dec = '0;
        imm = '0;
        case (opcode)
            core_pkg::OP:
            begin
                dec.op_writes_rf = 1'b1;
                dec.reads_rf1    = 1'b1;
                dec.reads_rf2    = 1'b1;
                dec.alu_op       = alu_sel(instr[14:12], instr[30]);
            end
            core_pkg::OP_IMM:
            begin
                dec.op_writes_rf = 1'b1;
                dec.reads_rf1    = 1'b1;
                dec.use_imm      = 1'b1;
                dec.alu_op       = alu_sel(instr[14:12], 1'b0);
                imm              = {{20{instr[31]}}, instr[31:20]};
            end
            core_pkg::LUI:
            begin
                dec.op_writes_rf = 1'b1;
                dec.use_imm      = 1'b1;
                dec.alu_op       = core_pkg::PASS_B;
                imm              = {instr[31:12], 12'b0};
            end
            core_pkg::LOAD:
            begin
                dec.op_writes_rf = 1'b1;
                dec.reads_rf1    = 1'b1;
                dec.is_load      = 1'b1;
                dec.use_imm      = 1'b1;
                imm              = {{20{instr[31]}}, instr[31:20]};
            end
            core_pkg::STORE:
            begin
                dec.reads_rf1 = 1'b1;
                dec.reads_rf2 = 1'b1;
                dec.is_store  = 1'b1;
                dec.use_imm   = 1'b1;
                imm           = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            core_pkg::BRANCH:
            begin
                dec.reads_rf1 = 1'b1;
                dec.reads_rf2 = 1'b1;
                dec.is_branch = 1'b1;
                // funct3 bit 0 tells BNE from BEQ
                dec.branch_ne = instr[12];
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            core_pkg::JAL:
            begin
                dec.op_writes_rf = 1'b1;
                dec.is_jump      = 1'b1;
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            // Unknown opcodes decode as a bubble
            default: dec = '0;
        endcase
    end

    // Unused sources read as x0 so forwarding never matches them
    assign rs1 = dec.reads_rf1 ? instr[19:15] : '0;
    assign rs2 = dec.reads_rf2 ? instr[24:20] : '0;

    reg_file reg_file_i (
        .clk        (clk),
        .rs1_addr_i (rs1),
        .rs2_addr_i (rs2),
        .wb_i       (wb_i),
        .rs1_val_o  (rf_rs1_val),
        .rs2_val_o  (rf_rs2_val)
    );

    // Bypass the value being written back this cycle
    assign rs1_val = (wb_i.op_writes_rf && (wb_i.rd == rs1) && (rs1 != '0)) ? wb_i.data
                                                                              : rf_rs1_val;
    assign rs2_val = (wb_i.op_writes_rf && (wb_i.rd == rs2) && (rs2 != '0)) ? wb_i.data
                                                                              : rf_rs2_val;

    always_ff @(posedge clk)
    begin
        if (reset || flush_i)
            id_exe_r <= '0;
        else if (!stall_i)
            id_exe_r <= '{valid:   fetch_id_i.valid,
                          pc:      fetch_id_i.pc,
                          decode:  dec,
                          rd:      instr[11:7],
                          rs1:     rs1,
                          rs2:     rs2,
                          rs1_val: rs1_val,
                          rs2_val: rs2_val,
                          imm:     imm};
    end

    assign id_exe_o = id_exe_r;

endmodule

/* hdl/reg_file.sv */
module reg_file (
    input  logic                                   clk,
    input  logic [core_pkg::REG_ADDR_WIDTH-1:0]    rs1_addr_i,
    input  logic [core_pkg::REG_ADDR_WIDTH-1:0]    rs2_addr_i,
    input  core_pkg::wb_s                          wb_i,
    output logic [core_pkg::XLEN-1:0]              rs1_val_o,
    output logic [core_pkg::XLEN-1:0]              rs2_val_o
);

    logic [core_pkg::XLEN-1:0] regs [2**core_pkg::REG_ADDR_WIDTH];

    // Single write port fed by the writeback register
    // Writes to x0 are dropped
    always_ff @(posedge clk)
    begin
        if (wb_i.op_writes_rf && (wb_i.rd != '0))
            regs[wb_i.rd] <= wb_i.data;
    end

    // Asynchronous reads, x0 hardwired to zero
    assign rs1_val_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_val_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

/* hdl/fetch_stage.sv */
module fetch_stage (
    input  logic                         clk,
    input  logic                         reset,
    input  core_pkg::net_packet_s        net_packet_i,
    input  logic                         stall_i,
    input  logic                         redirect_valid_i,
    input  logic [core_pkg::XLEN-1:0]    redirect_pc_i,
    output core_pkg::fetch_id_s          fetch_id_o,
    output core_pkg::state_e             state_o,
    output logic                         imem_write_o
);

    core_pkg::net_packet_s                 net_packet_r;
    core_pkg::state_e                      state_r;
    core_pkg::fetch_id_s                   fetch_id_r;
    logic [core_pkg::XLEN-1:0]             pc_r;
    logic [core_pkg::XLEN-1:0]             pc_n;
    logic                                  net_pc_write;
    logic                                  net_imem_write;
    logic                                  pc_write_idle;
    logic                                  pc_wen;
    logic [core_pkg::XLEN-1:0]             imem [2**core_pkg::IMEM_ADDR_WIDTH];
    logic [core_pkg::XLEN-1:0]             imem_q;
    logic [core_pkg::IMEM_ADDR_WIDTH-1:0]  imem_rd_idx;
    logic [core_pkg::IMEM_ADDR_WIDTH-1:0]  imem_wr_idx;

    // Packet commands act one cycle after the packet is registered
    assign net_pc_write   = net_packet_r.valid && (net_packet_r.op == core_pkg::PC);
    assign net_imem_write = net_packet_r.valid && (net_packet_r.op == core_pkg::INSTR);
    // PC writes only start the core, ignored once running
    assign pc_write_idle  = net_pc_write && (state_r == core_pkg::IDLE);

    // Next PC priority: network start, redirect, stall hold, sequential
    always_comb
    begin
        if (pc_write_idle)
            pc_n = net_packet_r.addr;
        else if (redirect_valid_i)
            pc_n = redirect_pc_i;
        else if (stall_i)
            pc_n = pc_r;
        else
            pc_n = pc_r + core_pkg::XLEN'(core_pkg::PC_STEP);
    end

    assign pc_wen      = pc_write_idle || redirect_valid_i || !stall_i;
    // Word index into the instruction memory
    assign imem_rd_idx = pc_n[2 +: core_pkg::IMEM_ADDR_WIDTH];
    assign imem_wr_idx = net_packet_r.addr[2 +: core_pkg::IMEM_ADDR_WIDTH];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            net_packet_r <= '0;
            state_r      <= core_pkg::IDLE;
            pc_r         <= '0;
        end
        else
        begin
            net_packet_r <= net_packet_i;
            pc_r         <= pc_n;
            if (pc_write_idle)
                state_r <= core_pkg::RUN;
        end
    end

    // Synchronous instruction memory, output belongs to pc_r
    // Read only when the PC moves so the word stays put otherwise
    always_ff @(posedge clk)
    begin
        if (net_imem_write)
            imem[imem_wr_idx] <= net_packet_r.data;
        else if (pc_wen)
            imem_q <= imem[imem_rd_idx];
    end

    // Fetch/decode register, squashed on start and on redirect
    always_ff @(posedge clk)
    begin
        if (reset || pc_write_idle || redirect_valid_i)
            fetch_id_r <= '0;
        else if (!stall_i)
            fetch_id_r <= '{valid: (state_r == core_pkg::RUN), pc: pc_r, instruction: imem_q};
    end

    assign fetch_id_o   = fetch_id_r;
    assign state_o      = state_r;
    // Execute stalls the pipeline for the write cycle
    assign imem_write_o = net_imem_write;

endmodule

/* hdl/core_pkg.sv */
package core_pkg;

    // Datapath and address widths
    localparam int XLEN            = 32;
    localparam int REG_ADDR_WIDTH  = 5;
    localparam int IMEM_ADDR_WIDTH = 8;
    localparam int PC_STEP         = 4;

    // RV32I major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_e;

    // ALU operations, PASS_B forwards operand b for LUI
    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        PASS_B
    } alu_op_e;

    // Network packet commands
    typedef enum logic [1:0] {
        NONE,
        PC,
        INSTR
    } net_op_e;

    // Core run state
    typedef enum logic {
        IDLE,
        RUN
    } state_e;

    typedef struct packed {
        logic            valid;
        net_op_e         op;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] data;
    } net_packet_s;

    // Data-memory request, held until ack
    typedef struct packed {
        logic            valid;
        logic            wen;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } mem_req_s;

    typedef struct packed {
        logic            ack;
        logic [XLEN-1:0] rdata;
    } mem_resp_s;

    typedef struct packed {
        logic    op_writes_rf;
        logic    reads_rf1;
        logic    reads_rf2;
        logic    is_load;
        logic    is_store;
        logic    is_branch;
        logic    is_jump;
        logic    use_imm;
        alu_op_e alu_op;
        logic    branch_ne;
    } decode_s;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instruction;
    } fetch_id_s;

    typedef struct packed {
        logic                      valid;
        logic [XLEN-1:0]           pc;
        decode_s                   decode;
        logic [REG_ADDR_WIDTH-1:0] rd;
        logic [REG_ADDR_WIDTH-1:0] rs1;
        logic [REG_ADDR_WIDTH-1:0] rs2;
        logic [XLEN-1:0]           rs1_val;
        logic [XLEN-1:0]           rs2_val;
        logic [XLEN-1:0]           imm;
    } id_exe_s;

    // Writeback register, also the register file write port
    typedef struct packed {
        logic                      op_writes_rf;
        logic [REG_ADDR_WIDTH-1:0] rd;
        logic [XLEN-1:0]           data;
    } wb_s;

endpackage
